//--- hw/vli_cfg.svh
`ifndef VLI_CFG_SVH
`define VLI_CFG_SVH

// Cluster size
`define VLI_NUM_INI    4
`define VLI_NUM_BANK   4

// Initiator side widths
`define VLI_ADDR_W     16  // Byte address
`define VLI_DATA_W     32  // One word
`define VLI_BE_W       4   // One enable per byte
`define VLI_BYTE_OFF_W 2

// Bank side widths
`define VLI_BANK_AW    6   // 64 words per bank
`define VLI_INI_W      2   // Initiator tag
`define VLI_BANK_W     2   // Bank select, just above byte offset

`endif

//--- hw/vli_pkg.sv
`include "vli_cfg.svh"

package vli_pkg;

  // Request opcode, replaces a plain write enable
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Bank FSM
  typedef enum logic [1:0] {
    BS_IDLE = 2'd0,  // Ready for a new request
    BS_WAIT = 2'd1,  // Counting latency
    BS_RESP = 2'd2   // Holding response until taken
  } bank_state_e;

  // Initiator request as seen at the top level
  typedef struct packed {
    op_e                    op;
    logic [`VLI_ADDR_W-1:0] addr;   // Byte address
    logic [`VLI_DATA_W-1:0] wdata;
    logic [`VLI_BE_W-1:0]   be;
  } ini_req_t;

  // Request after address split, tagged with its source
  typedef struct packed {
    op_e                     op;
    logic [`VLI_BANK_AW-1:0] waddr;  // Word address inside bank
    logic [`VLI_DATA_W-1:0]  wdata;
    logic [`VLI_BE_W-1:0]    be;
    logic [`VLI_INI_W-1:0]   ini;    // Return path
  } bank_req_t;

  typedef struct packed {
    logic [`VLI_DATA_W-1:0] rdata;  // Zero for writes
    logic [`VLI_INI_W-1:0]  ini;
  } bank_resp_t;

endpackage

//--- hw/vli_spill_reg.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

// Two-entry request buffer, output fully registered
module vli_spill_reg (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  output logic               ready_o,
  input  vli_pkg::ini_req_t  data_i,
  output logic               valid_o,
  input  logic               ready_i,
  output vli_pkg::ini_req_t  data_o
);

  logic [1:0]        cnt_q;     // Fill level, 0 to 2
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  vli_pkg::ini_req_t buf_q [2];
  logic              push;
  logic              pop;

  // Both flags come straight from state
  assign ready_o = (cnt_q != 2'd2);
  assign valid_o = (cnt_q != 2'd0);
  assign data_o  = buf_q[rd_ptr_q];  // Head entry

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q    <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= !wr_ptr_q;
      if (pop)  rd_ptr_q <= !rd_ptr_q;
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;  // Idle or pass-through
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- hw/vli_rr_arbiter.sv
`timescale 1ns/1ps

// Round-robin pick, priority moves past the winner on transfer
module vli_rr_arbiter #(
  parameter int unsigned NumReq = 4,
  parameter int unsigned IdxW   = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [NumReq-1:0] req_i,
  output logic [NumReq-1:0] gnt_o,
  output logic [IdxW-1:0]   idx_o,
  input  logic              ack_i   // Granted transfer done
);

  logic [IdxW-1:0] ptr_q;       // Highest priority slot
  logic [IdxW-1:0] lock_idx_q;  // Grant still pending
  logic            lock_q;
  logic [IdxW-1:0] win_idx;
  logic            found;

  always_comb begin
    int unsigned cand;
    cand    = 0;
    win_idx = lock_idx_q;
    found   = 1'b0;
    if (lock_q && req_i[lock_idx_q]) begin
      found = 1'b1;  // Keep an unacknowledged grant
    end else begin
      for (int k = 0; k < NumReq; k++) begin
        cand = (int'(ptr_q) + k) % NumReq;
        if (!found && req_i[cand]) begin
          found   = 1'b1;
          win_idx = IdxW'(cand);
        end
      end
    end
    gnt_o = '0;
    if (found) gnt_o[win_idx] = 1'b1;
  end

  assign idx_o = win_idx;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= found && !ack_i;
      lock_idx_q <= win_idx;
      if (ack_i) begin
        // Winner drops to lowest priority
        ptr_q <= (win_idx == IdxW'(NumReq - 1)) ? '0 : win_idx + 1'b1;
      end
    end
  end

endmodule

//--- hw/vli_xbar.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

// Full crossbar, combinational in both directions
module vli_xbar (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  // Initiator side
  input  logic [`VLI_NUM_INI-1:0]                       ini_valid_i,
  output logic [`VLI_NUM_INI-1:0]                       ini_ready_o,
  input  vli_pkg::ini_req_t [`VLI_NUM_INI-1:0]          ini_req_i,
  output logic [`VLI_NUM_INI-1:0]                       ini_resp_valid_o,
  input  logic [`VLI_NUM_INI-1:0]                       ini_resp_ready_i,
  output logic [`VLI_NUM_INI-1:0][`VLI_DATA_W-1:0]      ini_rdata_o,
  // Bank side
  output logic [`VLI_NUM_BANK-1:0]                      bank_valid_o,
  input  logic [`VLI_NUM_BANK-1:0]                      bank_ready_i,
  output vli_pkg::bank_req_t [`VLI_NUM_BANK-1:0]        bank_req_o,
  input  logic [`VLI_NUM_BANK-1:0]                      bank_resp_valid_i,
  output logic [`VLI_NUM_BANK-1:0]                      bank_resp_ready_o,
  input  vli_pkg::bank_resp_t [`VLI_NUM_BANK-1:0]       bank_resp_i
);

  localparam int unsigned WordLsb = `VLI_BYTE_OFF_W + `VLI_BANK_W;

  logic [`VLI_NUM_INI-1:0][`VLI_BANK_W-1:0]   bank_sel;  // Target bank per initiator
  logic [`VLI_NUM_BANK-1:0][`VLI_NUM_INI-1:0] req_vec;
  logic [`VLI_NUM_BANK-1:0][`VLI_NUM_INI-1:0] req_gnt;
  logic [`VLI_NUM_BANK-1:0][`VLI_INI_W-1:0]   req_idx;
  logic [`VLI_NUM_INI-1:0][`VLI_NUM_BANK-1:0] resp_vec;
  logic [`VLI_NUM_INI-1:0][`VLI_NUM_BANK-1:0] resp_gnt;
  logic [`VLI_NUM_INI-1:0][`VLI_BANK_W-1:0]   resp_idx;

  // Bank index sits just above the byte offset
  for (genvar i = 0; i < `VLI_NUM_INI; i++) begin : gen_ini_req
    assign bank_sel[i]    = ini_req_i[i].addr[`VLI_BYTE_OFF_W +: `VLI_BANK_W];
    // Ready only for the winner of the addressed bank
    assign ini_ready_o[i] = req_gnt[bank_sel[i]][i] && bank_ready_i[bank_sel[i]];
  end

  for (genvar b = 0; b < `VLI_NUM_BANK; b++) begin : gen_bank
    for (genvar i = 0; i < `VLI_NUM_INI; i++) begin : gen_vec
      assign req_vec[b][i] = ini_valid_i[i] && (int'(bank_sel[i]) == b);
    end

    vli_rr_arbiter #(
      .NumReq(`VLI_NUM_INI)
    ) i_req_arb (
      .clk_i   (clk_i                              ),
      .arst_n_i(arst_n_i                           ),
      .req_i   (req_vec[b]                         ),
      .gnt_o   (req_gnt[b]                         ),
      .idx_o   (req_idx[b]                         ),
      .ack_i   (bank_valid_o[b] && bank_ready_i[b] )
    );

    assign bank_valid_o[b] = |req_vec[b];

    // Split address and tag with source index
    always_comb begin
      bank_req_o[b].op    = ini_req_i[req_idx[b]].op;
      bank_req_o[b].waddr = ini_req_i[req_idx[b]].addr[WordLsb +: `VLI_BANK_AW];
      bank_req_o[b].wdata = ini_req_i[req_idx[b]].wdata;
      bank_req_o[b].be    = ini_req_i[req_idx[b]].be;
      bank_req_o[b].ini   = req_idx[b];
    end

    // Response ready from the initiator this bank answers
    assign bank_resp_ready_o[b] = resp_gnt[bank_resp_i[b].ini][b]
                               && ini_resp_ready_i[bank_resp_i[b].ini];
  end

  for (genvar i = 0; i < `VLI_NUM_INI; i++) begin : gen_ini_resp
    for (genvar b = 0; b < `VLI_NUM_BANK; b++) begin : gen_vec
      assign resp_vec[i][b] = bank_resp_valid_i[b] && (int'(bank_resp_i[b].ini) == i);
    end

    vli_rr_arbiter #(
      .NumReq(`VLI_NUM_BANK)
    ) i_resp_arb (
      .clk_i   (clk_i                                       ),
      .arst_n_i(arst_n_i                                    ),
      .req_i   (resp_vec[i]                                 ),
      .gnt_o   (resp_gnt[i]                                 ),
      .idx_o   (resp_idx[i]                                 ),
      .ack_i   (ini_resp_valid_o[i] && ini_resp_ready_i[i]  )
    );

    assign ini_resp_valid_o[i] = |resp_vec[i];
    assign ini_rdata_o[i]      = bank_resp_i[resp_idx[i]].rdata;  // Granted bank's data
  end

endmodule

//--- hw/vli_mem_bank.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

// Word memory, latency of 1 plus the two low word-address bits
module vli_mem_bank (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vli_pkg::bank_req_t   req_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output vli_pkg::bank_resp_t  resp_o
);

  localparam int unsigned Depth = 2 ** `VLI_BANK_AW;

  vli_pkg::bank_state_e   state_q;
  logic [1:0]             lat_cnt_q;  // Remaining wait cycles
  logic [`VLI_DATA_W-1:0] mem_q [Depth];
  logic [`VLI_DATA_W-1:0] rdata_q;
  logic [`VLI_INI_W-1:0]  ini_q;
  logic                   accept;

  // Input stalls while a response is pending
  assign req_ready_o  = (state_q == vli_pkg::BS_IDLE);
  assign accept       = req_valid_i && req_ready_o;
  assign resp_valid_o = (state_q == vli_pkg::BS_RESP);
  assign resp_o.rdata = rdata_q;
  assign resp_o.ini   = ini_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= vli_pkg::BS_IDLE;
      lat_cnt_q <= 2'd0;
    end else begin
      case (state_q)
        vli_pkg::BS_IDLE: begin
          if (accept) begin
            if (req_i.waddr[1:0] == 2'd0) begin
              state_q <= vli_pkg::BS_RESP;  // Single cycle
            end else begin
              state_q   <= vli_pkg::BS_WAIT;
              lat_cnt_q <= req_i.waddr[1:0] - 2'd1;
            end
          end
        end
        vli_pkg::BS_WAIT: begin
          if (lat_cnt_q == 2'd0) state_q <= vli_pkg::BS_RESP;
          else                   lat_cnt_q <= lat_cnt_q - 2'd1;
        end
        vli_pkg::BS_RESP: begin
          if (resp_ready_i) state_q <= vli_pkg::BS_IDLE;  // Taken
        end
        default: state_q <= vli_pkg::BS_IDLE;
      endcase
    end
  end

  // Array access and captured response
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ini_q <= req_i.ini;
      if (req_i.op == vli_pkg::OP_WRITE) begin
        rdata_q <= '0;
        for (int k = 0; k < `VLI_BE_W; k++) begin
          if (req_i.be[k]) mem_q[req_i.waddr][8*k +: 8] <= req_i.wdata[8*k +: 8];
        end
      end else begin
        rdata_q <= mem_q[req_i.waddr];
      end
    end
  end

endmodule

//--- hw/vli_top.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

// Shared-memory cluster: spill regs, crossbar, banks
module vli_top (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic [`VLI_NUM_INI-1:0]                  req_valid_i,
  output logic [`VLI_NUM_INI-1:0]                  req_ready_o,
  input  vli_pkg::ini_req_t [`VLI_NUM_INI-1:0]     req_i,
  output logic [`VLI_NUM_INI-1:0]                  resp_valid_o,
  input  logic [`VLI_NUM_INI-1:0]                  resp_ready_i,
  output logic [`VLI_NUM_INI-1:0][`VLI_DATA_W-1:0] resp_rdata_o
);

  // Spill register to crossbar
  logic [`VLI_NUM_INI-1:0]                spill_valid;
  logic [`VLI_NUM_INI-1:0]                spill_ready;
  vli_pkg::ini_req_t [`VLI_NUM_INI-1:0]   spill_req;
  // Crossbar to banks
  logic [`VLI_NUM_BANK-1:0]               bank_valid;
  logic [`VLI_NUM_BANK-1:0]               bank_ready;
  vli_pkg::bank_req_t [`VLI_NUM_BANK-1:0] bank_req;
  logic [`VLI_NUM_BANK-1:0]               bank_resp_valid;
  logic [`VLI_NUM_BANK-1:0]               bank_resp_ready;
  vli_pkg::bank_resp_t [`VLI_NUM_BANK-1:0] bank_resp;

  for (genvar i = 0; i < `VLI_NUM_INI; i++) begin : gen_spill
    vli_spill_reg i_spill (
      .clk_i   (clk_i         ),
      .arst_n_i(arst_n_i      ),
      .valid_i (req_valid_i[i]),
      .ready_o (req_ready_o[i]),
      .data_i  (req_i[i]      ),
      .valid_o (spill_valid[i]),
      .ready_i (spill_ready[i]),
      .data_o  (spill_req[i]  )
    );
  end

  vli_xbar i_xbar (
    .clk_i            (clk_i          ),
    .arst_n_i         (arst_n_i       ),
    .ini_valid_i      (spill_valid    ),
    .ini_ready_o      (spill_ready    ),
    .ini_req_i        (spill_req      ),
    .ini_resp_valid_o (resp_valid_o   ),
    .ini_resp_ready_i (resp_ready_i   ),
    .ini_rdata_o      (resp_rdata_o   ),
    .bank_valid_o     (bank_valid     ),
    .bank_ready_i     (bank_ready     ),
    .bank_req_o       (bank_req       ),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ready_o(bank_resp_ready),
    .bank_resp_i      (bank_resp      )
  );

  for (genvar b = 0; b < `VLI_NUM_BANK; b++) begin : gen_bank
    vli_mem_bank i_bank (
      .clk_i       (clk_i             ),
      .arst_n_i    (arst_n_i          ),
      .req_valid_i (bank_valid[b]     ),
      .req_ready_o (bank_ready[b]     ),
      .req_i       (bank_req[b]       ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b]),
      .resp_o      (bank_resp[b]      )
    );
  end

endmodule

//--- tb/vli_monitor.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

// Compares every response with the value expected for its initiator
module vli_monitor (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic [`VLI_NUM_INI-1:0]                  req_valid_i,
  input  logic [`VLI_NUM_INI-1:0]                  req_ready_i,
  input  logic [`VLI_NUM_INI-1:0]                  resp_valid_i,
  input  logic [`VLI_NUM_INI-1:0]                  resp_ready_i,
  input  logic [`VLI_NUM_INI-1:0][`VLI_DATA_W-1:0] resp_rdata_i,
  input  logic [`VLI_NUM_INI-1:0][`VLI_DATA_W-1:0] exp_rdata_i,
  input  int unsigned                              test_idx_i,
  input  logic                                     test_end_i,  // One-cycle pulse
  output int unsigned                              err_cnt_o,
  output int unsigned                              chk_cnt_o,
  output int unsigned                              test_cnt_o,
  output int unsigned                              test_fail_o
);

  int unsigned             req_cnt [`VLI_NUM_INI];
  int unsigned             resp_cnt [`VLI_NUM_INI];
  int unsigned             test_err;  // Errors in the running test
  logic [`VLI_NUM_INI-1:0] pend;

  function automatic string test_name(input int unsigned idx);
    case (idx)
      0:       return "fill";
      1:       return "write_read";
      2:       return "byte_enable";
      3:       return "same_bank";
      4:       return "random_bp";
      5:       return "readout";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `VLI_NUM_INI; i++) begin
        req_cnt[i]  = 0;
        resp_cnt[i] = 0;
      end
      pend        = '0;
      test_err    = 0;
      err_cnt_o   = 0;
      chk_cnt_o   = 0;
      test_cnt_o  = 0;
      test_fail_o = 0;
    end else begin
      for (int i = 0; i < `VLI_NUM_INI; i++) begin
        if (req_valid_i[i] && req_ready_i[i]) begin
          req_cnt[i]++;
          pend[i] = 1'b1;
        end
        if (resp_valid_i[i] && resp_ready_i[i]) begin
          resp_cnt[i]++;
          chk_cnt_o++;
          if (!pend[i]) begin
            $display("ERROR %s: initiator %0d got a response with no request open",
                     test_name(test_idx_i), i);
            test_err++;
          end else if (resp_rdata_i[i] !== exp_rdata_i[i]) begin
            $display("MISMATCH %s ini %0d: expected %h actual %h",
                     test_name(test_idx_i), i, exp_rdata_i[i], resp_rdata_i[i]);
            test_err++;
          end
          pend[i] = 1'b0;
        end
      end
      if (test_end_i) begin
        // Lost or doubled responses show up as a count difference
        for (int i = 0; i < `VLI_NUM_INI; i++) begin
          if (req_cnt[i] != resp_cnt[i]) begin
            $display("ERROR %s: initiator %0d sent %0d requests but got %0d responses",
                     test_name(test_idx_i), i, req_cnt[i], resp_cnt[i]);
            test_err++;
          end
        end
        $display("test %-12s %s, %0d errors", test_name(test_idx_i),
                 (test_err == 0) ? "passed" : "FAILED", test_err);
        test_cnt_o++;
        if (test_err != 0) test_fail_o++;
        err_cnt_o += test_err;
        test_err   = 0;
      end
    end
  end

endmodule

//--- tb/vli_chk.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

// Handshake rules at the cluster ports
module vli_chk (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic [`VLI_NUM_INI-1:0]                  req_valid_i,
  input  logic [`VLI_NUM_INI-1:0]                  req_ready_i,
  input  vli_pkg::ini_req_t [`VLI_NUM_INI-1:0]     req_i,
  input  logic [`VLI_NUM_INI-1:0]                  resp_valid_i,
  input  logic [`VLI_NUM_INI-1:0]                  resp_ready_i,
  input  logic [`VLI_NUM_INI-1:0][`VLI_DATA_W-1:0] resp_rdata_i
);

  int unsigned                   fail_cnt = 0;  // Failed assertions so far
  logic [`VLI_NUM_INI-1:0][3:0]  pend_q;        // Open requests per initiator

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= '0;
    end else begin
      for (int i = 0; i < `VLI_NUM_INI; i++) begin
        pend_q[i] <= pend_q[i] + 4'(req_valid_i[i] && req_ready_i[i])
                   - 4'(resp_valid_i[i] && resp_ready_i[i]);
      end
    end
  end

  // Banks idle during reset
  a_rst_quiet: assert property (@(posedge clk_i) !arst_n_i |-> resp_valid_i == '0)
    else begin fail_cnt++; $error("response valid while reset is applied"); end

  for (genvar i = 0; i < `VLI_NUM_INI; i++) begin : gen_ini
    a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_valid_i[i] && !req_ready_i[i] |=> req_valid_i[i] && $stable(req_i[i]))
      else begin fail_cnt++; $error("request on initiator %0d changed while stalled", i); end
    a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_i[i] && !resp_ready_i[i] |=> resp_valid_i[i] && $stable(resp_rdata_i[i]))
      else begin fail_cnt++; $error("response on initiator %0d changed while stalled", i); end
    a_resp_cause: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_i[i] |-> pend_q[i] != '0)
      else begin fail_cnt++; $error("response on initiator %0d without a request", i); end
  end

endmodule

bind vli_top vli_chk i_chk (
  .clk_i       (clk_i       ),
  .arst_n_i    (arst_n_i    ),
  .req_valid_i (req_valid_i ),
  .req_ready_i (req_ready_o ),
  .req_i       (req_i       ),
  .resp_valid_i(resp_valid_o),
  .resp_ready_i(resp_ready_i),
  .resp_rdata_i(resp_rdata_o)
);

//--- tb/vli_tb.sv
`timescale 1ns/1ps
`include "vli_cfg.svh"

module vli_tb;

  localparam int unsigned ClkPeriod = 40;
  localparam int unsigned NumIni    = `VLI_NUM_INI;
  localparam int unsigned WordIdxW  = `VLI_BANK_AW + `VLI_BANK_W;
  localparam int unsigned Words     = 2 ** WordIdxW;  // Whole cluster
  localparam int unsigned RandReqs  = 40;             // Per initiator
  localparam int unsigned NumTests  = 6;
  // Fill and readout, plus directed and random requests of every initiator
  localparam int unsigned TotalReqs = 2 * Words + NumIni * (2 + 4 + 2 + RandReqs);

  logic                               clk    = 1'b0;
  logic                               arst_n = 1'b1;
  logic [NumIni-1:0]                  req_valid;
  logic [NumIni-1:0]                  req_ready;
  vli_pkg::ini_req_t [NumIni-1:0]     req;
  logic [NumIni-1:0]                  resp_valid;
  logic [NumIni-1:0]                  resp_ready;
  logic [NumIni-1:0][`VLI_DATA_W-1:0] resp_rdata;
  logic [NumIni-1:0][`VLI_DATA_W-1:0] exp_rdata;  // Held while a request is open
  logic                               bp_en;      // Random response stalls
  logic                               test_end;
  int unsigned                        test_idx;
  int unsigned                        err_cnt;
  int unsigned                        chk_cnt;
  int unsigned                        test_cnt;
  int unsigned                        test_fail;
  logic [`VLI_DATA_W-1:0]             shadow [Words];  // Indexed by byte address [9:2]
  logic [31:0]                        rng_state = 32'd76;

  vli_top uut (
    .clk_i       (clk       ),
    .arst_n_i    (arst_n    ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_i       (req       ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata)
  );

  vli_monitor i_mon (
    .clk_i       (clk       ),
    .arst_n_i    (arst_n    ),
    .req_valid_i (req_valid ),
    .req_ready_i (req_ready ),
    .resp_valid_i(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_i(resp_rdata),
    .exp_rdata_i (exp_rdata ),
    .test_idx_i  (test_idx  ),
    .test_end_i  (test_end  ),
    .err_cnt_o   (err_cnt   ),
    .chk_cnt_o   (chk_cnt   ),
    .test_cnt_o  (test_cnt  ),
    .test_fail_o (test_fail )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Byte address from bank and word inside the bank
  function automatic logic [`VLI_ADDR_W-1:0] mk_addr(input logic [1:0] bank,
                                                    input logic [5:0] waddr);
    return {6'd0, waddr, bank, 2'b00};
  endfunction

  // Shadow memory update, returns the rdata a response must carry
  function automatic logic [`VLI_DATA_W-1:0] ref_access(input vli_pkg::ini_req_t r);
    logic [WordIdxW-1:0] w;
    w = r.addr[`VLI_BYTE_OFF_W +: WordIdxW];
    if (r.op == vli_pkg::OP_READ) return shadow[w];
    for (int k = 0; k < `VLI_BE_W; k++) begin
      if (r.be[k]) shadow[w][8*k +: 8] = r.wdata[8*k +: 8];
    end
    return '0;  // Writes answer with zero
  endfunction

  task automatic issue(input int unsigned i, input vli_pkg::op_e op,
                       input logic [`VLI_ADDR_W-1:0] addr,
                       input logic [`VLI_DATA_W-1:0] wdata, input logic [3:0] be);
    vli_pkg::ini_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.be    = be;
    @(posedge clk);
    exp_rdata[i] <= ref_access(r);
    req[i]       <= r;
    req_valid[i] <= 1'b1;
    @(posedge clk);
    while (!req_ready[i]) @(posedge clk);
    req_valid[i] <= 1'b0;
    @(posedge clk);
    while (!(resp_valid[i] && resp_ready[i])) @(posedge clk);  // Response done
  endtask

  // Initiator i owns the words whose low two bank-word bits equal i
  task automatic run_phase(input int unsigned p, input int unsigned i);
    logic [31:0]             r;
    logic [1:0]              own;
    logic [`VLI_ADDR_W-1:0]  a;
    own = 2'(i);
    case (p)
      0: begin
        for (int w = 0; w < Words / NumIni; w++) begin
          a = mk_addr(2'(w), {4'(w >> 2), own});
          issue(i, vli_pkg::OP_WRITE, a, {a, ~a}, 4'hF);
        end
      end
      1: begin
        a = mk_addr(own, {4'd5, own});
        issue(i, vli_pkg::OP_WRITE, a, xorshift(), 4'hF);
        issue(i, vli_pkg::OP_READ, a, '0, 4'h0);
      end
      2: begin  // Partial writes merge with old bytes
        a = mk_addr(~own, {4'd12, own});
        issue(i, vli_pkg::OP_WRITE, a, xorshift(), 4'hF);
        issue(i, vli_pkg::OP_WRITE, a, xorshift(), 4'b0101);
        issue(i, vli_pkg::OP_WRITE, a, xorshift(), 4'b1000);
        issue(i, vli_pkg::OP_READ, a, '0, 4'h0);
      end
      3: begin
        a = mk_addr(2'd2, {4'd9, own});  // Everyone on bank 2
        issue(i, vli_pkg::OP_WRITE, a, xorshift(), 4'hF);
        issue(i, vli_pkg::OP_READ, a, '0, 4'h0);
      end
      4: begin
        for (int n = 0; n < RandReqs; n++) begin
          r = xorshift();
          a = mk_addr(r[1:0], {r[5:2], own});
          issue(i, vli_pkg::op_e'(r[6]), a, xorshift(), r[11:8]);
        end
      end
      5: begin
        if (i == 0) begin
          for (int w = 0; w < Words; w++) begin
            issue(i, vli_pkg::OP_READ, mk_addr(2'(w), 6'(w >> 2)), '0, 4'h0);
          end
        end
      end
      default: ;
    endcase
  endtask

  // Response stalls, ready about three cycles in four
  always @(posedge clk) begin : bp_gen
    logic [31:0] r;
    r = xorshift();
    resp_ready <= bp_en ? (r[3:0] | r[7:4]) : '1;
  end

  initial begin
    #(TotalReqs * 20 * ClkPeriod);
    $display("Timeout: run did not finish within %0d cycles", TotalReqs * 20);
    $display("Something failed");
    $finish;
  end

  initial begin
    arst_n     = 1'b0;
    req_valid  = '0;
    req        = '0;
    resp_ready = '1;
    exp_rdata  = '0;
    bp_en      = 1'b0;
    test_end   = 1'b0;
    test_idx   = 0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    for (int unsigned p = 0; p < NumTests; p++) begin
      @(posedge clk);
      bp_en    <= (p == 4);
      test_idx <= p;
      fork
        run_phase(p, 0);
        run_phase(p, 1);
        run_phase(p, 2);
        run_phase(p, 3);
      join
      @(posedge clk);
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
    end
    @(posedge clk);
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, test_fail, chk_cnt, err_cnt, uut.i_chk.fail_cnt);
    if (err_cnt == 0 && test_fail == 0 && uut.i_chk.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/vli_pkg.sv
hw/vli_spill_reg.sv
hw/vli_rr_arbiter.sv
hw/vli_xbar.sv
hw/vli_mem_bank.sv
hw/vli_top.sv
tb/vli_monitor.sv
tb/vli_chk.sv
tb/vli_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vli_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Something failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
